/* aluLane.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dual_cfg.svh"

module aluLane import dualPkg::*; (
	input  logic               clk_i,
	input  logic               reset_i,
	input  logic               valid_i,
	input  decoded_s           op_i,
	input  logic [`DATA_W-1:0] srcA_i,
	input  logic [`DATA_W-1:0] srcB_i,
	output wbLane_s            exe_o,
	output wbLane_s            wb_o
);
	logic               exeValid;
	decoded_s           exeOp;
	logic [`DATA_W-1:0] exeA;
	logic [`DATA_W-1:0] exeB;
	logic [`DATA_W-1:0] opB;
	logic [`DATA_W-1:0] result;

	// execute register
	always_ff @(posedge clk_i) begin
		exeOp <= op_i;
		exeA <= srcA_i;
		exeB <= srcB_i;
		if (reset_i) begin
			exeValid <= 1'b0;
		end else begin
			exeValid <= valid_i;
		end
	end

	assign opB = exeOp.useRt ? exeB : exeOp.imm;

	always_comb begin
		case (exeOp.aluOp)
			ADD:     result = exeA + opB;
			SUB:     result = exeA - opB;
			AND:     result = exeA & opB;
			OR:      result = exeA | opB;
			XOR:     result = exeA ^ opB;
			SLT:     result = {{(`DATA_W - 1){1'b0}}, $signed(exeA) < $signed(opB)};
			// upper immediate already shifted by the decoder
			LUI:     result = opB;
			default: result = '0;
		endcase
	end

	assign exe_o = '{
		en:   exeValid & exeOp.writeEn,
		addr: exeOp.dest,
		data: result,
		pc:   exeOp.pc
	};

	// writeback register
	always_ff @(posedge clk_i) begin
		wb_o.addr <= exe_o.addr;
		wb_o.data <= exe_o.data;
		wb_o.pc <= exe_o.pc;
		if (reset_i) begin
			wb_o.en <= 1'b0;
		end else begin
			wb_o.en <= exe_o.en;
		end
	end

endmodule

`default_nettype wire

/* dualCore.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dual_cfg.svh"

module dualCore import dualPkg::*; (
	input  logic               clk_i,
	input  logic               reset_i,
	input  logic               fetchOk1_i,
	input  logic               fetchOk2_i,
	input  logic [`DATA_W-1:0] fetchData1_i,
	input  logic [`DATA_W-1:0] fetchData2_i,
	output logic [`DATA_W-1:0] fetchPc_o,
	output logic               fetchFull_o,
	output wbLane_s            wbMaster_o,
	output wbLane_s            wbSlave_o
);
	instWord_u          headWord;
	instWord_u          nextWord;
	logic [`DATA_W-1:0] headPc;
	logic [`DATA_W-1:0] nextPc;
	logic [`QUEUE_AW:0] count;
	logic               issueMaster;
	logic               issueSlave;
	decoded_s           masterOp;
	decoded_s           slaveOp;
	logic [`DATA_W-1:0] rfMasterA;
	logic [`DATA_W-1:0] rfMasterB;
	logic [`DATA_W-1:0] rfSlaveA;
	logic [`DATA_W-1:0] rfSlaveB;
	logic [`DATA_W-1:0] masterA;
	logic [`DATA_W-1:0] masterB;
	logic [`DATA_W-1:0] slaveA;
	logic [`DATA_W-1:0] slaveB;
	wbLane_s            exeMaster;
	wbLane_s            exeSlave;

	instQueue u_instQueue (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.fetchOk1_i   (fetchOk1_i),
		.fetchOk2_i   (fetchOk2_i),
		.fetchData1_i (fetchData1_i),
		.fetchData2_i (fetchData2_i),
		.pop1_i       (issueMaster),
		.pop2_i       (issueSlave),
		.headWord_o   (headWord),
		.nextWord_o   (nextWord),
		.headPc_o     (headPc),
		.nextPc_o     (nextPc),
		.count_o      (count),
		.full_o       (fetchFull_o),
		.fetchPc_o    (fetchPc_o)
	);

	// queue head feeds the master, the entry behind it the slave
	instDecoder u_decMaster (
		.word_i (headWord),
		.pc_i   (headPc),
		.op_o   (masterOp)
	);

	instDecoder u_decSlave (
		.word_i (nextWord),
		.pc_i   (nextPc),
		.op_o   (slaveOp)
	);

	issueCtrl u_issueCtrl (
		.count_i       (count),
		.masterOp_i    (masterOp),
		.slaveOp_i     (slaveOp),
		.issueMaster_o (issueMaster),
		.issueSlave_o  (issueSlave)
	);

	regFile u_regFile (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.raddr0_i   (masterOp.srcA),
		.raddr1_i   (masterOp.srcB),
		.raddr2_i   (slaveOp.srcA),
		.raddr3_i   (slaveOp.srcB),
		.rdata0_o   (rfMasterA),
		.rdata1_o   (rfMasterB),
		.rdata2_o   (rfSlaveA),
		.rdata3_o   (rfSlaveB),
		.wbMaster_i (wbMaster_o),
		.wbSlave_i  (wbSlave_o)
	);

	operandForward u_fwdMasterA (
		.addr_i      (masterOp.srcA),
		.regData_i   (rfMasterA),
		.exeMaster_i (exeMaster),
		.exeSlave_i  (exeSlave),
		.wbMaster_i  (wbMaster_o),
		.wbSlave_i   (wbSlave_o),
		.value_o     (masterA)
	);

	operandForward u_fwdMasterB (
		.addr_i      (masterOp.srcB),
		.regData_i   (rfMasterB),
		.exeMaster_i (exeMaster),
		.exeSlave_i  (exeSlave),
		.wbMaster_i  (wbMaster_o),
		.wbSlave_i   (wbSlave_o),
		.value_o     (masterB)
	);

	operandForward u_fwdSlaveA (
		.addr_i      (slaveOp.srcA),
		.regData_i   (rfSlaveA),
		.exeMaster_i (exeMaster),
		.exeSlave_i  (exeSlave),
		.wbMaster_i  (wbMaster_o),
		.wbSlave_i   (wbSlave_o),
		.value_o     (slaveA)
	);

	operandForward u_fwdSlaveB (
		.addr_i      (slaveOp.srcB),
		.regData_i   (rfSlaveB),
		.exeMaster_i (exeMaster),
		.exeSlave_i  (exeSlave),
		.wbMaster_i  (wbMaster_o),
		.wbSlave_i   (wbSlave_o),
		.value_o     (slaveB)
	);

	aluLane u_laneMaster (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.valid_i (issueMaster),
		.op_i    (masterOp),
		.srcA_i  (masterA),
		.srcB_i  (masterB),
		.exe_o   (exeMaster),
		.wb_o    (wbMaster_o)
	);

	aluLane u_laneSlave (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.valid_i (issueSlave),
		.op_i    (slaveOp),
		.srcA_i  (slaveA),
		.srcB_i  (slaveB),
		.exe_o   (exeSlave),
		.wb_o    (wbSlave_o)
	);

endmodule

`default_nettype wire

/* dualPkg.sv */
`default_nettype none
`include "dual_cfg.svh"

package dualPkg;

	// R-type view of an instruction word
	typedef struct packed {
		logic [5:0]         op;
		logic [`REG_AW-1:0] rs;
		logic [`REG_AW-1:0] rt;
		logic [`REG_AW-1:0] rd;
		logic [4:0]         shamt;
		logic [5:0]         funct;
	} rFmt_s;

	// I-type view of the same word
	typedef struct packed {
		logic [5:0]         op;
		logic [`REG_AW-1:0] rs;
		logic [`REG_AW-1:0] rt;
		logic [15:0]        imm;
	} iFmt_s;

	typedef union packed {
		rFmt_s rFmt;
		iFmt_s iFmt;
	} instWord_u;

	typedef enum logic [2:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SLT,
		LUI
	} aluOp_e;

	typedef struct packed {
		aluOp_e             aluOp;
		logic [`REG_AW-1:0] srcA;
		logic [`REG_AW-1:0] srcB;
		// second operand from rt, else from imm
		logic               useRt;
		logic [`DATA_W-1:0] imm;
		logic [`REG_AW-1:0] dest;
		logic               writeEn;
		logic [`DATA_W-1:0] pc;
	} decoded_s;

	// one register write leaving a lane
	typedef struct packed {
		logic               en;
		logic [`REG_AW-1:0] addr;
		logic [`DATA_W-1:0] data;
		logic [`DATA_W-1:0] pc;
	} wbLane_s;

endpackage

`default_nettype wire

/* dual_cfg.svh */
`ifndef DUAL_CFG_SVH
`define DUAL_CFG_SVH

// datapath and register widths
`define DATA_W      32
`define REG_AW      5

// instruction queue geometry
`define QUEUE_DEPTH 8
`define QUEUE_AW    3

// address of the first fetched word
`define PC_RESET    32'h0000_0000

// major opcodes
`define OP_SPECIAL  6'h00
`define OP_ADDIU    6'h09
`define OP_ANDI     6'h0c
`define OP_ORI      6'h0d
`define OP_XORI     6'h0e
`define OP_LUI      6'h0f

// funct field of SPECIAL
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_XOR      6'h26
`define FN_SLT      6'h2a

`endif

/* instDecoder.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dual_cfg.svh"

module instDecoder import dualPkg::*; (
	input  instWord_u          word_i,
	input  logic [`DATA_W-1:0] pc_i,
	output decoded_s           op_o
);
	logic defined;

	always_comb begin
		op_o = '0;
		defined = 1'b1;
		op_o.srcA = word_i.iFmt.rs;
		op_o.srcB = word_i.iFmt.rt;
		op_o.pc = pc_i;
		// I-type writes rt unless overridden below
		op_o.dest = word_i.iFmt.rt;
		op_o.aluOp = ADD;

		case (word_i.iFmt.op)
			`OP_SPECIAL: begin
				op_o.useRt = 1'b1;
				op_o.dest = word_i.rFmt.rd;
				case (word_i.rFmt.funct)
					`FN_ADDU: op_o.aluOp = ADD;
					`FN_SUBU: op_o.aluOp = SUB;
					`FN_AND:  op_o.aluOp = AND;
					`FN_OR:   op_o.aluOp = OR;
					`FN_XOR:  op_o.aluOp = XOR;
					`FN_SLT:  op_o.aluOp = SLT;
					default:  defined = 1'b0;
				endcase
			end
			`OP_ADDIU: begin
				op_o.imm = {{16{word_i.iFmt.imm[15]}}, word_i.iFmt.imm};
			end
			`OP_ANDI: begin
				op_o.aluOp = AND;
				op_o.imm = {16'h0000, word_i.iFmt.imm};
			end
			`OP_ORI: begin
				op_o.aluOp = OR;
				op_o.imm = {16'h0000, word_i.iFmt.imm};
			end
			`OP_XORI: begin
				op_o.aluOp = XOR;
				op_o.imm = {16'h0000, word_i.iFmt.imm};
			end
			`OP_LUI: begin
				op_o.aluOp = LUI;
				op_o.imm = {word_i.iFmt.imm, 16'h0000};
			end
			default: defined = 1'b0;
		endcase

		// r0 writes and unknown words retire silently
		op_o.writeEn = defined & (op_o.dest != '0);
	end

endmodule

`default_nettype wire

/* instQueue.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dual_cfg.svh"

module instQueue import dualPkg::*; (
	input  logic               clk_i,
	input  logic               reset_i,
	input  logic               fetchOk1_i,
	input  logic               fetchOk2_i,
	input  logic [`DATA_W-1:0] fetchData1_i,
	input  logic [`DATA_W-1:0] fetchData2_i,
	input  logic               pop1_i,
	input  logic               pop2_i,
	output instWord_u          headWord_o,
	output instWord_u          nextWord_o,
	output logic [`DATA_W-1:0] headPc_o,
	output logic [`DATA_W-1:0] nextPc_o,
	output logic [`QUEUE_AW:0] count_o,
	output logic               full_o,
	output logic [`DATA_W-1:0] fetchPc_o
);
	instWord_u            wordMem [`QUEUE_DEPTH];
	logic [`DATA_W-1:0]   pcMem [`QUEUE_DEPTH];
	logic [`QUEUE_AW-1:0] wrPtr;
	logic [`QUEUE_AW-1:0] rdPtr;
	logic [`QUEUE_AW-1:0] slot2;
	logic [`QUEUE_AW-1:0] rdNext;
	logic                 acc1;
	logic                 acc2;
	logic [`QUEUE_AW:0]   nPush;
	logic [`QUEUE_AW:0]   nPop;

	// strobes are dropped while fewer than two slots are free
	assign full_o = count_o >= (`QUEUE_DEPTH - 1);
	assign acc1 = fetchOk1_i & ~full_o;
	assign acc2 = fetchOk2_i & ~full_o;
	assign nPush = {{`QUEUE_AW{1'b0}}, acc1} + {{`QUEUE_AW{1'b0}}, acc2};
	assign nPop = {{`QUEUE_AW{1'b0}}, pop1_i} + {{`QUEUE_AW{1'b0}}, pop2_i};

	// a lone second word takes the first free slot
	assign slot2 = wrPtr + {{(`QUEUE_AW - 1){1'b0}}, acc1};
	assign rdNext = rdPtr + 1'b1;

	always_ff @(posedge clk_i) begin
		if (acc1) begin
			wordMem[wrPtr] <= fetchData1_i;
			pcMem[wrPtr] <= fetchPc_o;
		end
		if (acc2) begin
			wordMem[slot2] <= fetchData2_i;
			pcMem[slot2] <= fetchPc_o + {{(`DATA_W - 3){1'b0}}, acc1, 2'b00};
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count_o <= '0;
			fetchPc_o <= `PC_RESET;
		end else begin
			wrPtr <= wrPtr + nPush[`QUEUE_AW-1:0];
			rdPtr <= rdPtr + nPop[`QUEUE_AW-1:0];
			count_o <= count_o + nPush - nPop;
			fetchPc_o <= fetchPc_o + {{(`DATA_W - `QUEUE_AW - 3){1'b0}}, nPush, 2'b00};
		end
	end

	assign headWord_o = wordMem[rdPtr];
	assign headPc_o = pcMem[rdPtr];
	assign nextWord_o = wordMem[rdNext];
	assign nextPc_o = pcMem[rdNext];

endmodule

`default_nettype wire

/* issueCtrl.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dual_cfg.svh"

module issueCtrl import dualPkg::*; (
	input  logic [`QUEUE_AW:0] count_i,
	input  decoded_s           masterOp_i,
	input  decoded_s           slaveOp_i,
	output logic               issueMaster_o,
	output logic               issueSlave_o
);
	logic hazA;
	logic hazB;
	logic depend;
	logic twoReady;

	// slave reading what the master writes in the same cycle
	assign hazA = slaveOp_i.srcA == masterOp_i.dest;
	// immediate ops never read rt
	assign hazB = slaveOp_i.useRt & (slaveOp_i.srcB == masterOp_i.dest);
	assign depend = masterOp_i.writeEn & (hazA | hazB);

	assign twoReady = count_i > 1;

	// the master goes whenever the queue holds a word
	assign issueMaster_o = count_i != '0;

	// the slave pairs up only if independent of the master
	assign issueSlave_o = issueMaster_o & twoReady & ~depend;

endmodule

`default_nettype wire

/* list.f */
+incdir+.
dualPkg.sv
instQueue.sv
instDecoder.sv
issueCtrl.sv
regFile.sv
operandForward.sv
aluLane.sv
dualCore.sv
tb_dualCore.sv

/* operandForward.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dual_cfg.svh"

module operandForward import dualPkg::*; (
	input  logic [`REG_AW-1:0] addr_i,
	input  logic [`DATA_W-1:0] regData_i,
	input  wbLane_s            exeMaster_i,
	input  wbLane_s            exeSlave_i,
	input  wbLane_s            wbMaster_i,
	input  wbLane_s            wbSlave_i,
	output logic [`DATA_W-1:0] value_o
);

	// newest producer first, slave before master in each stage
	always_comb begin
		if (addr_i == '0) begin
			value_o = '0;
		end else if (exeSlave_i.en && exeSlave_i.addr == addr_i) begin
			value_o = exeSlave_i.data;
		end else if (exeMaster_i.en && exeMaster_i.addr == addr_i) begin
			value_o = exeMaster_i.data;
		end else if (wbSlave_i.en && wbSlave_i.addr == addr_i) begin
			value_o = wbSlave_i.data;
		end else if (wbMaster_i.en && wbMaster_i.addr == addr_i) begin
			value_o = wbMaster_i.data;
		end else begin
			// anything older is already in the register file
			value_o = regData_i;
		end
	end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dual_cfg.svh"

module regFile import dualPkg::*; (
	input  logic               clk_i,
	input  logic               reset_i,
	input  logic [`REG_AW-1:0] raddr0_i,
	input  logic [`REG_AW-1:0] raddr1_i,
	input  logic [`REG_AW-1:0] raddr2_i,
	input  logic [`REG_AW-1:0] raddr3_i,
	output logic [`DATA_W-1:0] rdata0_o,
	output logic [`DATA_W-1:0] rdata1_o,
	output logic [`DATA_W-1:0] rdata2_o,
	output logic [`DATA_W-1:0] rdata3_o,
	input  wbLane_s            wbMaster_i,
	input  wbLane_s            wbSlave_i
);
	logic [`DATA_W-1:0] regs [2**`REG_AW];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < 2**`REG_AW; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (wbMaster_i.en) begin
				regs[wbMaster_i.addr] <= wbMaster_i.data;
			end
			// slave is younger, so it lands last on a shared address
			if (wbSlave_i.en) begin
				regs[wbSlave_i.addr] <= wbSlave_i.data;
			end
		end
	end

	// r0 is hardwired to zero
	assign rdata0_o = (raddr0_i == '0) ? '0 : regs[raddr0_i];
	assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];
	assign rdata3_o = (raddr3_i == '0) ? '0 : regs[raddr3_i];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_dualCore -f list.f -o simDual &&
out=$(./obj_dir/simDual 2>&1) &&
echo "$out" &&
echo "$out" | grep -qx "=== PASS ===" ||
{ echo "simulation failed"; exit 1; }

/* tb_dualCore.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dual_cfg.svh"

module tb_dualCore import dualPkg::*; ();
	localparam int NUM_WORDS = 400;
	localparam int CYCLE_LIMIT = 4 * NUM_WORDS + 50;
	localparam int DRAIN_CYCLES = 10;

	// one expected register write, in program order
	typedef struct packed {
		logic [31:0]        idx;
		logic [`REG_AW-1:0] addr;
		logic [`DATA_W-1:0] data;
		logic [`DATA_W-1:0] pc;
		logic               readsRs;
		logic [`REG_AW-1:0] rs;
		logic               readsRt;
		logic [`REG_AW-1:0] rt;
	} expWrite_s;

	logic               clk;
	logic               reset;
	logic               fetchOk1;
	logic               fetchOk2;
	logic [`DATA_W-1:0] fetchData1;
	logic [`DATA_W-1:0] fetchData2;
	logic [`DATA_W-1:0] fetchPc;
	logic               fetchFull;
	wbLane_s            wbMaster;
	wbLane_s            wbSlave;

	logic [`DATA_W-1:0] refRegs [32];
	expWrite_s          expected [$];
	int pushed, skipped, seen, dualWrites, sameAddrPairs;
	int lastRetired, checks, errors, cycles;

	dualCore uut (
		.clk_i        (clk),
		.reset_i      (reset),
		.fetchOk1_i   (fetchOk1),
		.fetchOk2_i   (fetchOk2),
		.fetchData1_i (fetchData1),
		.fetchData2_i (fetchData2),
		.fetchPc_o    (fetchPc),
		.fetchFull_o  (fetchFull),
		.wbMaster_o   (wbMaster),
		.wbSlave_o    (wbSlave)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// run limit in clock cycles
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles with %0d writes still pending", cycles, expected.size());
		$display("=== FAIL ===");
		$finish;
	end

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic checkTrue(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			$display("%s", what);
			errors++;
		end
	endtask

	function automatic logic [31:0] makeWord();
		logic [4:0]  rs, rt, rd;
		logic [15:0] imm;
		int          kind;
		// few registers so that dependences are frequent
		rs = 5'($urandom % 8);
		rt = 5'($urandom % 8);
		rd = 5'($urandom % 8);
		imm = 16'($urandom);
		kind = int'($urandom % 20);
		if (kind == 0) begin
			// a load opcode, outside the kept set
			return {6'h23, rs, rt, imm};
		end
		case (kind % 11)
			0:       return {`OP_SPECIAL, rs, rt, rd, 5'd0, `FN_ADDU};
			1:       return {`OP_SPECIAL, rs, rt, rd, 5'd0, `FN_SUBU};
			2:       return {`OP_SPECIAL, rs, rt, rd, 5'd0, `FN_AND};
			3:       return {`OP_SPECIAL, rs, rt, rd, 5'd0, `FN_OR};
			4:       return {`OP_SPECIAL, rs, rt, rd, 5'd0, `FN_XOR};
			5:       return {`OP_SPECIAL, rs, rt, rd, 5'd0, `FN_SLT};
			6:       return {`OP_ADDIU, rs, rt, imm};
			7:       return {`OP_ANDI, rs, rt, imm};
			8:       return {`OP_ORI, rs, rt, imm};
			9:       return {`OP_XORI, rs, rt, imm};
			default: return {`OP_LUI, rs, rt, imm};
		endcase
	endfunction

	// reference execution at push time, words arrive in program order
	task automatic pushWord(input logic [31:0] word);
		logic [5:0]  op, fn;
		logic [4:0]  rs, rt, rd, dest;
		logic [15:0] imm;
		logic [31:0] a, b, res;
		logic        defined;
		logic        rtRead;
		expWrite_s   e;
		op = word[31:26];
		rs = word[25:21];
		rt = word[20:16];
		rd = word[15:11];
		imm = word[15:0];
		fn = word[5:0];
		a = refRegs[rs];
		b = refRegs[rt];
		defined = 1'b1;
		rtRead = 1'b0;
		res = '0;
		dest = rt;
		if (op == `OP_SPECIAL) begin
			dest = rd;
			rtRead = 1'b1;
			case (fn)
				`FN_ADDU: res = a + b;
				`FN_SUBU: res = a - b;
				`FN_AND:  res = a & b;
				`FN_OR:   res = a | b;
				`FN_XOR:  res = a ^ b;
				`FN_SLT:  res = {31'b0, $signed(a) < $signed(b)};
				default:  defined = 1'b0;
			endcase
		end else begin
			case (op)
				`OP_ADDIU: res = a + {{16{imm[15]}}, imm};
				`OP_ANDI:  res = a & {16'h0000, imm};
				`OP_ORI:   res = a | {16'h0000, imm};
				`OP_XORI:  res = a ^ {16'h0000, imm};
				`OP_LUI:   res = {imm, 16'h0000};
				default:   defined = 1'b0;
			endcase
		end
		if (defined && dest != 5'd0) begin
			refRegs[dest] = res;
			e.idx = 32'(pushed);
			e.addr = dest;
			e.data = res;
			e.pc = `PC_RESET + 32'(pushed) * 32'd4;
			e.readsRs = (op != `OP_LUI);
			e.rs = rs;
			e.readsRt = rtRead;
			e.rt = rt;
			expected.push_back(e);
		end else begin
			skipped++;
		end
		pushed++;
	endtask

	task automatic compareWrite(input string name, input wbLane_s got, input expWrite_s exp);
		checkValue({name, ".addr"}, 32'(got.addr), 32'(exp.addr));
		checkValue({name, ".data"}, got.data, exp.data);
		checkValue({name, ".pc"}, got.pc, exp.pc);
		lastRetired = int'(exp.idx);
		seen++;
	endtask

	task automatic checkWriteback();
		expWrite_s m, s;
		logic      haveMaster;
		haveMaster = 1'b0;
		if (wbMaster.en) begin
			checkTrue(expected.size() > 0, "master lane wrote back with no write pending");
			if (expected.size() > 0) begin
				m = expected.pop_front();
				compareWrite("wbMaster_o", wbMaster, m);
				haveMaster = 1'b1;
			end
		end
		if (wbSlave.en) begin
			checkTrue(expected.size() > 0, "slave lane wrote back with no write pending");
			if (expected.size() > 0) begin
				s = expected.pop_front();
				compareWrite("wbSlave_o", wbSlave, s);
				// a paired slave must not read what its master writes
				if (haveMaster) begin
					dualWrites++;
					if (m.addr == s.addr) begin
						sameAddrPairs++;
					end
					checkTrue(!(s.readsRs && s.rs == m.addr) && !(s.readsRt && s.rt == m.addr),
						$sformatf("slave at pc %h issued with master at pc %h it depends on",
						s.pc, m.pc));
				end
			end
		end
	endtask

	task automatic checkFetchSide();
		int outstanding;
		// words still possibly in the queue
		outstanding = pushed - (lastRetired + 1);
		checkValue("fetchPc_o", fetchPc, `PC_RESET + 32'(pushed) * 32'd4);
		checkTrue(!fetchFull || outstanding >= `QUEUE_DEPTH - 1,
			$sformatf("queue reported full with only %0d words outstanding", outstanding));
	endtask

	task automatic driveFetch();
		int strobe;
		fetchOk1 = 1'b0;
		fetchOk2 = 1'b0;
		// idle data lines carry junk
		fetchData1 = $urandom;
		fetchData2 = $urandom;
		if (!fetchFull && pushed < NUM_WORDS) begin
			strobe = int'($urandom % 4);
			if (strobe == 3 && pushed == NUM_WORDS - 1) begin
				strobe = 1;
			end
			if (strobe == 1 || strobe == 3) begin
				fetchData1 = makeWord();
				fetchOk1 = 1'b1;
				pushWord(fetchData1);
			end
			if (strobe == 2 || strobe == 3) begin
				fetchData2 = makeWord();
				fetchOk2 = 1'b1;
				pushWord(fetchData2);
			end
		end
	endtask

	task automatic stepCycle();
		@(posedge clk);
		#5;
		checkWriteback();
		checkFetchSide();
		driveFetch();
	endtask

	initial begin
		int errBefore;
		void'($urandom(81));
		reset = 1'b1;
		fetchOk1 = 1'b0;
		fetchOk2 = 1'b0;
		fetchData1 = '0;
		fetchData2 = '0;
		pushed = 0;
		skipped = 0;
		seen = 0;
		dualWrites = 0;
		sameAddrPairs = 0;
		lastRetired = -1;
		checks = 0;
		errors = 0;
		for (int r = 0; r < 32; r++) begin
			refRegs[r] = '0;
		end
		repeat (2) @(posedge clk);
		#5;
		reset = 1'b0;

		errBefore = errors;
		checkValue("wbMaster_o.en", 32'(wbMaster.en), 32'd0);
		checkValue("wbSlave_o.en", 32'(wbSlave.en), 32'd0);
		checkValue("fetchFull_o", 32'(fetchFull), 32'd0);
		checkValue("fetchPc_o", fetchPc, `PC_RESET);
		$display("test reset state: %0d errors", errors - errBefore);

		errBefore = errors;
		while (pushed < NUM_WORDS || expected.size() != 0) begin
			stepCycle();
		end
		$display("test random stream: %0d words, %0d writes, %0d paired, %0d same addr, %0d errors",
			pushed, seen, dualWrites, sameAddrPairs, errors - errBefore);

		// any late or extra writeback is flagged while idling here
		errBefore = errors;
		repeat (DRAIN_CYCLES) stepCycle();
		$display("test drain: %0d silent words, %0d errors", skipped, errors - errBefore);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire
